/* alu_adder.sv */
`default_nettype none

module alu_adder (
  input  alu_data_pkg::data_t a,
  input  alu_data_pkg::data_t b,
  input  alu_op_pkg::op_t     op,
  output alu_data_pkg::data_t sum,
  output logic                overflow
);

  import alu_data_pkg::*;
  import alu_op_pkg::*;

  data_t operand_b;
  logic  carry_in;
  data_t raw_sum;
  logic  raw_overflow;
  logic  less_equal;

  //////////////////////////////////////////////////
  // Operand select for the shared adder
  //////////////////////////////////////////////////
  always_comb begin
    operand_b = b;
    carry_in  = 1'b0;
    case (op)
      // a + ~b + 1
      op_sub, op_sle: begin
        operand_b = ~b;
        carry_in  = 1'b1;
      end
      // a + ~1 + 1 is a - 1
      op_dec: begin
        operand_b = ~data_t'(1);
        carry_in  = 1'b1;
      end
      op_inc: operand_b = data_t'(1);
      default: operand_b = b;
    endcase
  end

  assign raw_sum = a + operand_b + data_t'(carry_in);

  // Same sign in, other sign out
  assign raw_overflow = (a[data_width-1] == operand_b[data_width-1]) &&
                        (raw_sum[data_width-1] != a[data_width-1]);

  // a <= b when the difference is zero or its corrected sign is negative
  assign less_equal = (raw_sum == '0) || (raw_sum[data_width-1] ^ raw_overflow);

  //////////////////////////////////////////////////
  // Result and overflow for owned ops only
  //////////////////////////////////////////////////
  always_comb begin
    sum      = '0;
    overflow = 1'b0;
    case (op)
      op_sub, op_add, op_dec, op_inc: begin
        sum      = raw_sum;
        overflow = raw_overflow;
      end
      op_sle: sum = data_t'(less_equal);
      default: sum = '0;
    endcase
  end

endmodule

`default_nettype wire

/* alu_data_pkg.sv */
`default_nettype none

package alu_data_pkg;

  localparam int data_width  = 16;
  localparam int shamt_width = $clog2(data_width);

  // Operands and results
  typedef logic [data_width-1:0]  data_t;
  // Shift amount within one word
  typedef logic [shamt_width-1:0] shamt_t;

  // One request per cycle, 36 bits
  typedef struct packed {
    data_t           a;
    data_t           b;
    alu_op_pkg::op_t op;
  } alu_req_t;

  // Registered response, 18 bits
  typedef struct packed {
    data_t s;
    logic  overflow;
    logic  zero;
  } alu_rsp_t;

endpackage

`default_nettype wire

/* alu_logic.sv */
`default_nettype none

module alu_logic (
  input  alu_data_pkg::data_t a,
  input  alu_data_pkg::data_t b,
  input  alu_op_pkg::op_t     op,
  output alu_data_pkg::data_t result
);

  import alu_data_pkg::*;
  import alu_op_pkg::*;

  data_t and_result;
  data_t or_result;
  data_t not_result;

  assign and_result = a & b;
  assign or_result  = a | b;
  // NOT works on a alone
  assign not_result = ~a;

  always_comb begin
    case (op)
      op_and:  result = and_result;
      op_or:   result = or_result;
      op_not:  result = not_result;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* alu_op_pkg.sv */
`default_nettype none

package alu_op_pkg;

  localparam int op_width = 4;
  localparam int op_count = 2 ** op_width;

  // Op code and a one bit per code mask
  typedef logic [op_width-1:0] op_t;
  typedef logic [op_count-1:0] op_mask_t;

  // Op codes
  localparam op_t op_sub = 4'd0;
  localparam op_t op_add = 4'd1;
  localparam op_t op_or  = 4'd2;
  localparam op_t op_and = 4'd3;
  localparam op_t op_dec = 4'd4;
  localparam op_t op_inc = 4'd5;
  localparam op_t op_not = 4'd6;
  localparam op_t op_sla = 4'd7;
  localparam op_t op_sra = 4'd8;
  localparam op_t op_sll = 4'd9;
  localparam op_t op_srl = 4'd10;
  localparam op_t op_sle = 4'd11;

  // Unit classes, one bit set for each op code the unit owns
  localparam op_mask_t adder_ops = (op_mask_t'(1) << op_sub) | (op_mask_t'(1) << op_add) |
                                   (op_mask_t'(1) << op_dec) | (op_mask_t'(1) << op_inc) |
                                   (op_mask_t'(1) << op_sle);
  localparam op_mask_t logic_ops = (op_mask_t'(1) << op_or) | (op_mask_t'(1) << op_and) |
                                   (op_mask_t'(1) << op_not);
  localparam op_mask_t shift_ops = (op_mask_t'(1) << op_sla) | (op_mask_t'(1) << op_sra) |
                                   (op_mask_t'(1) << op_sll) | (op_mask_t'(1) << op_srl);

  // Codes 12 to 15 are in no class and give a zero result

endpackage

`default_nettype wire

/* alu_output_stage.sv */
`default_nettype none

module alu_output_stage (
  input  logic                   clk,
  input  logic                   arst_n,
  input  alu_op_pkg::op_t        op,
  input  alu_data_pkg::data_t    adder_sum,
  input  logic                   adder_overflow,
  input  alu_data_pkg::data_t    logic_result,
  input  alu_data_pkg::data_t    shift_result,
  output alu_data_pkg::alu_rsp_t rsp
);

  import alu_data_pkg::*;
  import alu_op_pkg::*;

  data_t    sel_result;
  alu_rsp_t rsp_next;

  //////////////////////////////////////////////////
  // Result select by unit class
  //////////////////////////////////////////////////
  always_comb begin
    if (adder_ops[op]) begin
      sel_result = adder_sum;
    end else if (logic_ops[op]) begin
      sel_result = logic_result;
    end else if (shift_ops[op]) begin
      sel_result = shift_result;
    end else begin
      // Unused codes
      sel_result = '0;
    end
  end

  //////////////////////////////////////////////////
  // Flags
  //////////////////////////////////////////////////
  always_comb begin
    rsp_next.s        = sel_result;
    // Adder already drives 0 outside its own ops
    rsp_next.overflow = adder_overflow;
    rsp_next.zero     = (sel_result == '0);
  end

  //////////////////////////////////////////////////
  // Output register, one cycle of latency
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp <= '0;
    end else begin
      rsp <= rsp_next;
    end
  end

endmodule

`default_nettype wire

/* alu_shifter.sv */
`default_nettype none

module alu_shifter (
  input  alu_data_pkg::data_t a,
  input  alu_data_pkg::data_t b,
  input  alu_op_pkg::op_t     op,
  output alu_data_pkg::data_t result
);

  import alu_data_pkg::*;
  import alu_op_pkg::*;

  shamt_t amount;
  logic   too_far;
  data_t  sign_fill;
  data_t  signed_shift;
  data_t  left_result;
  data_t  right_logical;
  data_t  right_arith;

  // Low bits give the distance, any upper bit means a full shift
  assign amount  = b[shamt_width-1:0];
  assign too_far = |b[data_width-1:shamt_width];

  assign sign_fill = {data_width{a[data_width-1]}};

  // Sign-filling shift of a
  assign signed_shift = $signed(a) >>> amount;

  assign left_result   = too_far ? '0        : (a << amount);
  assign right_logical = too_far ? '0        : (a >> amount);
  assign right_arith   = too_far ? sign_fill : signed_shift;

  //////////////////////////////////////////////////
  // Op decode
  //////////////////////////////////////////////////
  always_comb begin
    case (op)
      // Both left shifts fill with zeros
      op_sla, op_sll: result = left_result;
      op_srl:         result = right_logical;
      op_sra:         result = right_arith;
      default:        result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* alu_top.sv */
`default_nettype none

module alu_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  alu_data_pkg::alu_req_t req,
  output alu_data_pkg::alu_rsp_t rsp
);

  import alu_data_pkg::*;

  data_t adder_sum;
  logic  adder_overflow;
  data_t logic_result;
  data_t shift_result;

  //////////////////////////////////////////////////
  // Combinational units
  //////////////////////////////////////////////////
  alu_adder i_adder (
    .a        (req.a),
    .b        (req.b),
    .op       (req.op),
    .sum      (adder_sum),
    .overflow (adder_overflow)
  );

  alu_logic i_logic (
    .a      (req.a),
    .b      (req.b),
    .op     (req.op),
    .result (logic_result)
  );

  // b carries the shift amount
  alu_shifter i_shifter (
    .a      (req.a),
    .b      (req.b),
    .op     (req.op),
    .result (shift_result)
  );

  //////////////////////////////////////////////////
  // Select and register
  //////////////////////////////////////////////////
  alu_output_stage i_output_stage (
    .clk            (clk),
    .arst_n         (arst_n),
    .op             (req.op),
    .adder_sum      (adder_sum),
    .adder_overflow (adder_overflow),
    .logic_result   (logic_result),
    .shift_result   (shift_result),
    .rsp            (rsp)
  );

endmodule

`default_nettype wire

/* flist.f */
alu_op_pkg.sv
alu_data_pkg.sv
alu_adder.sv
alu_logic.sv
alu_shifter.sv
alu_output_stage.sv
alu_top.sv
tb_alu_top.sv

/* run.sh */
#!/bin/sh
# Build the ALU testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f flist.f \
  --top-module tb_alu_top \
  -o sim_alu

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/sim_alu

/* tb_alu_top.sv */
`default_nettype none

module tb_alu_top;

  timeunit 1ns;
  timeprecision 1ps;

  import alu_data_pkg::*;
  import alu_op_pkg::*;

  localparam int reset_cycles   = 10;
  localparam int random_count   = 2000;
  // Arith, logic, shift sweep and compare cases
  localparam int directed_count = 15 + 6 + 4 * 3 * 7 + 13;
  localparam int cycle_limit    = 2 * (random_count + directed_count) + reset_cycles;

  localparam int max_pos = 2 ** (data_width - 1) - 1;
  localparam int min_neg = -(2 ** (data_width - 1));

  localparam data_t shift_amounts [7] = '{16'd0, 16'd1, 16'd15, 16'd16, 16'd17,
                                          16'h8000, 16'hffff};
  localparam data_t shift_operands [3] = '{16'h8001, 16'h7ff3, 16'hffff};
  localparam op_t   shift_codes [4] = '{op_sla, op_sra, op_sll, op_srl};

  logic     clk = 1'b0;
  logic     arst_n;
  alu_req_t req;
  alu_rsp_t rsp;

  integer   seed;
  int       cycle_count;
  int       check_count;
  alu_req_t prev_req;
  logic     prev_valid;

  alu_top i_dut (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .rsp    (rsp)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Expected response from signed integer math
  //////////////////////////////////////////////////
  function automatic alu_rsp_t expected_rsp(input alu_req_t r);
    int       sa;
    int       sb;
    int       ua;
    int       ub;
    int       wide;
    data_t    s;
    logic     ovf;
    alu_rsp_t e;
    sa   = int'($signed(r.a));
    sb   = int'($signed(r.b));
    ua   = int'(r.a);
    ub   = int'(r.b);
    wide = 0;
    s    = '0;
    ovf  = 1'b0;
    case (r.op)
      op_sub, op_add, op_dec, op_inc: begin
        if (r.op == op_sub) wide = sa - sb;
        else if (r.op == op_add) wide = sa + sb;
        else if (r.op == op_dec) wide = sa - 1;
        else wide = sa + 1;
        ovf = (wide > max_pos) || (wide < min_neg);
        s   = data_t'(wide);
      end
      op_and: s = r.a & r.b;
      op_or:  s = r.a | r.b;
      op_not: s = ~r.a;
      // Both left shifts fill with zeros
      op_sla, op_sll: s = (ub >= data_width) ? '0 : data_t'(ua << ub);
      op_srl: s = (ub >= data_width) ? '0 : data_t'(ua >> ub);
      op_sra: begin
        if (ub >= data_width) s = (sa < 0) ? '1 : '0;
        else s = data_t'(sa >>> ub);
      end
      op_sle: s = (sa <= sb) ? data_t'(1) : '0;
      default: s = '0;
    endcase
    e.s        = s;
    e.overflow = ovf;
    e.zero     = (s == '0);
    return e;
  endfunction

  task automatic check_data(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Wrong value on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Wrong value on %s", name);
    end
  endtask

  //////////////////////////////////////////////////
  // Compare on the falling edge, one cycle behind
  //////////////////////////////////////////////////
  always @(negedge clk) begin : compare
    alu_rsp_t exp_rsp;
    if (!arst_n || !prev_valid) begin
      // Reset value until the first edge with arst_n high
      check_data("rsp.s", rsp.s, '0);
      check_bit("rsp.overflow", rsp.overflow, 1'b0);
      check_bit("rsp.zero", rsp.zero, 1'b0);
      prev_valid = arst_n;
    end else begin
      exp_rsp = expected_rsp(prev_req);
      check_data("rsp.s", rsp.s, exp_rsp.s);
      check_bit("rsp.overflow", rsp.overflow, exp_rsp.overflow);
      check_bit("rsp.zero", rsp.zero, exp_rsp.zero);
      check_count++;
    end
    prev_req = req;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "Timeout after %0d cycles, the tests did not finish", cycle_count);
    end
  end

  task automatic send(input data_t a, input data_t b, input op_t op);
    alu_req_t r;
    r.a  = a;
    r.b  = b;
    r.op = op;
    @(posedge clk);
    req <= r;
  endtask

  //////////////////////////////////////////////////
  // Directed cases
  //////////////////////////////////////////////////
  task automatic arith_cases();
    send(16'h7fff, 16'h0001, op_add);
    send(16'h8000, 16'hffff, op_add);
    send(16'h1234, 16'h4321, op_add);
    send(16'hffff, 16'h0001, op_add);
    send(16'h8000, 16'h8000, op_add);
    send(16'h8000, 16'h0001, op_sub);
    send(16'h0000, 16'h8000, op_sub);
    send(16'h0001, 16'h8000, op_sub);
    send(16'h0005, 16'h0005, op_sub);
    send(16'hffff, 16'h7fff, op_sub);
    send(16'h7fff, 16'h0000, op_inc);
    send(16'hffff, 16'h0000, op_inc);
    send(16'h8000, 16'h0000, op_dec);
    send(16'h0000, 16'h0000, op_dec);
    send(16'h0001, 16'h0000, op_dec);
  endtask

  task automatic logic_cases();
    send(16'hf0f0, 16'h3c3c, op_and);
    send(16'haaaa, 16'h5555, op_and);
    send(16'hf0f0, 16'h0f0f, op_or);
    send(16'h0000, 16'h0000, op_or);
    // All ones inverted gives zero
    send(16'hffff, 16'h1234, op_not);
    send(16'h1234, 16'hffff, op_not);
  endtask

  task automatic shift_sweep();
    foreach (shift_codes[c]) begin
      foreach (shift_operands[v]) begin
        foreach (shift_amounts[n]) begin
          send(shift_operands[v], shift_amounts[n], shift_codes[c]);
        end
      end
    end
  endtask

  task automatic compare_and_unused();
    send(16'h8000, 16'h7fff, op_sle);
    send(16'h7fff, 16'h8000, op_sle);
    send(16'h0005, 16'h0005, op_sle);
    send(16'hffff, 16'h0000, op_sle);
    send(16'h0000, 16'hffff, op_sle);
    send(16'h8000, 16'h8000, op_sle);
    send(16'h7fff, 16'h7fff, op_sle);
    // Difference overflows in these two
    send(16'h8000, 16'h0001, op_sle);
    send(16'h7fff, 16'hffff, op_sle);
    for (int c = 12; c < 16; c++) begin
      send(16'hffff, 16'h1234, op_t'(c));
    end
  endtask

  task automatic random_traffic();
    data_t a;
    data_t b;
    op_t   op;
    for (int i = 0; i < random_count; i++) begin
      a  = data_t'($random(seed));
      b  = data_t'($random(seed));
      op = op_t'($random(seed));
      // Small amounts half the time so shifts stay interesting
      if (($random(seed) & 1) != 0) b = b & 16'h001f;
      send(a, b, op);
    end
  endtask

  initial begin
    seed        = 92338;
    arst_n      = 1'b0;
    req         = '0;
    cycle_count = 0;
    check_count = 0;
    prev_req    = '0;
    prev_valid  = 1'b0;

    repeat (reset_cycles) @(posedge clk);
    arst_n <= 1'b1;

    arith_cases();
    logic_cases();
    shift_sweep();
    compare_and_unused();
    random_traffic();

    // Let the last request reach rsp and get compared
    repeat (3) @(posedge clk);

    if (check_count >= random_count) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Only %0d responses were compared", check_count);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Too few responses were checked");
    end
  end

endmodule

`default_nettype wire
